// File: source/mmacc_params.svh
// Sizes, widths and APB register map of the accumulation engine
`ifndef MMACC_PARAMS_SVH
`define MMACC_PARAMS_SVH

// ==========================================================================
// GRAM geometry
// ==========================================================================
`define GRAM_NB    2
`define LANES      4
`define LANE_W     2
`define MOD_Q_W    32
`define GRAM_ADD_W 6
`define GRAM_ID_W  1

// ==========================================================================
// APB map
// ==========================================================================
`define APB_ADD_W         12
`define APB_DATA_W        32
`define APB_CTRL_OFS      12'h000
`define APB_STATUS_OFS    12'h004
`define APB_COUNT_OFS     12'h008
// Window select, bank select and lowest address bit
`define APB_GRAM_BIT      11
`define APB_GRAM_BANK_BIT 9
`define APB_GRAM_ADD_LSB  3

`endif

// File: source/gram_pkg.sv
// GRAM types: coefficient-group address, bank id, bank one-hot, coefficient
`include "mmacc_params.svh"

package gram_pkg;

  // Address of one group of LANES coefficients
  typedef logic [`GRAM_ADD_W-1:0] gram_add_t;

  // Bank number
  typedef logic [`GRAM_ID_W-1:0] gram_id_t;

  // One bit per bank
  typedef logic [`GRAM_NB-1:0] gram_1h_t;

  // Single coefficient, arithmetic wraps at 2^MOD_Q_W
  typedef logic [`MOD_Q_W-1:0] coef_t;

endpackage

// File: source/mmacc_pkg.sv
// Control types: APB register selector and APB slave FSM states
package mmacc_pkg;

  // ==========================================================================
  // Register selector
  // ==========================================================================
  typedef enum logic [1:0] {
    REG_CTRL   = 2'd0,
    REG_STATUS = 2'd1,
    REG_COUNT  = 2'd2,
    // Coefficient window from 0x800 upward
    REG_GRAM   = 2'd3
  } apb_reg_e;

  // ==========================================================================
  // APB slave FSM
  // ==========================================================================
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    // Waiting for the arbiter to free the bank
    WAIT_GRANT = 2'd1,
    READ_DATA  = 2'd2,
    DONE       = 2'd3
  } apb_state_e;

endpackage

// File: source/gram_bank.sv
// GRAM bank: LANES-wide coefficient RAM with lane write enables
`timescale 1ns/10ps
`include "mmacc_params.svh"

module gram_bank (
  input  logic                                clk,
  input  logic                                s_rst_n,
  input  logic                                rd_en,
  input  gram_pkg::gram_add_t                 rd_add,
  output gram_pkg::coef_t [`LANES-1:0]        rd_data,
  output logic                                rd_data_avail,
  input  logic [`LANES-1:0]                   wr_en,
  input  gram_pkg::gram_add_t                 wr_add,
  input  gram_pkg::coef_t [`LANES-1:0]        wr_data
);

  // One entry per coefficient group
  gram_pkg::coef_t [`LANES-1:0] mem [0:(1 << `GRAM_ADD_W)-1];

  // Lane-masked write
  always_ff @(posedge clk) begin
    for (int l = 0; l < `LANES; l++) begin
      if (wr_en[l]) begin
        mem[wr_add][l] <= wr_data[l];
      end
    end
  end

  // Registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_add];
    end
  end

  // Avail follows rd_en by one cycle
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_data_avail <= 1'b0;
    end else begin
      rd_data_avail <= rd_en;
    end
  end

endmodule

// File: source/gram_arbiter.sv
// GRAM arbiter: per-bank port mux between accumulation pipeline and APB
`timescale 1ns/10ps
`include "mmacc_params.svh"

module gram_arbiter (
  input  logic                                          clk,
  input  logic                                          s_rst_n,
  input  gram_pkg::gram_1h_t                            busy_1h,
  input  gram_pkg::gram_1h_t                            prod_bank_1h,
  // Pipeline side
  input  logic [`GRAM_NB-1:0]                           acc_gram_rd_en,
  input  gram_pkg::gram_add_t [`GRAM_NB-1:0]            acc_gram_rd_add,
  output gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    gram_acc_rd_data,
  output logic [`GRAM_NB-1:0]                           gram_acc_rd_data_avail,
  input  logic [`GRAM_NB-1:0][`LANES-1:0]               acc_gram_wr_en,
  input  gram_pkg::gram_add_t [`GRAM_NB-1:0]            acc_gram_wr_add,
  input  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    acc_gram_wr_data,
  output gram_pkg::gram_1h_t                            garb_acc_wr_avail_1h,
  // APB side
  input  logic                                          apb_gram_req,
  input  logic                                          apb_gram_wr,
  input  gram_pkg::gram_id_t                            apb_gram_bank,
  input  gram_pkg::gram_add_t                           apb_gram_add,
  input  logic [`LANE_W-1:0]                            apb_gram_lane,
  input  gram_pkg::coef_t                               apb_gram_wdata,
  output logic                                          apb_gram_gnt,
  output gram_pkg::coef_t                               apb_gram_rdata,
  // Bank side
  output logic [`GRAM_NB-1:0]                           gram_rd_en,
  output gram_pkg::gram_add_t [`GRAM_NB-1:0]            gram_rd_add,
  input  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    gram_rd_data,
  input  logic [`GRAM_NB-1:0]                           gram_rd_data_avail,
  output logic [`GRAM_NB-1:0][`LANES-1:0]               gram_wr_en,
  output gram_pkg::gram_add_t [`GRAM_NB-1:0]            gram_wr_add,
  output gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    gram_wr_data
);

  gram_pkg::gram_1h_t  apb_bank_1h;
  gram_pkg::gram_1h_t  apb_gnt_1h;
  logic                apb_rd_q;
  gram_pkg::gram_id_t  apb_rd_bank_q;
  logic [`LANE_W-1:0]  apb_rd_lane_q;

  // ==========================================================================
  // Grant
  // ==========================================================================
  assign apb_bank_1h  = gram_pkg::gram_1h_t'(1) << apb_gram_bank;
  // Bank must be idle and not taking a new product this cycle
  assign apb_gram_gnt = apb_gram_req & ~|(apb_bank_1h & (busy_1h | prod_bank_1h));
  assign apb_gnt_1h   = {`GRAM_NB{apb_gram_gnt}} & apb_bank_1h;

  assign garb_acc_wr_avail_1h = ~apb_gnt_1h;

  // Port mux per bank
  always_comb begin
    for (int b = 0; b < `GRAM_NB; b++) begin
      if (apb_gnt_1h[b]) begin
        gram_rd_en[b]   = ~apb_gram_wr;
        gram_rd_add[b]  = apb_gram_add;
        gram_wr_en[b]   = apb_gram_wr ? (`LANES'(1) << apb_gram_lane) : '0;
        gram_wr_add[b]  = apb_gram_add;
        // Same word on all lanes, the enable picks one
        gram_wr_data[b] = {`LANES{apb_gram_wdata}};
      end else begin
        gram_rd_en[b]   = acc_gram_rd_en[b];
        gram_rd_add[b]  = acc_gram_rd_add[b];
        gram_wr_en[b]   = acc_gram_wr_en[b];
        gram_wr_add[b]  = acc_gram_wr_add[b];
        gram_wr_data[b] = acc_gram_wr_data[b];
      end
    end
  end

  // ==========================================================================
  // Read return
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      apb_rd_q <= 1'b0;
    end else begin
      apb_rd_q <= apb_gram_gnt & ~apb_gram_wr;
    end
  end

  always_ff @(posedge clk) begin
    apb_rd_bank_q <= apb_gram_bank;
    apb_rd_lane_q <= apb_gram_lane;
  end

  assign apb_gram_rdata   = gram_rd_data[apb_rd_bank_q][apb_rd_lane_q];
  assign gram_acc_rd_data = gram_rd_data;

  // Hide APB-owned reads from the pipeline
  always_comb begin
    for (int b = 0; b < `GRAM_NB; b++) begin
      gram_acc_rd_data_avail[b] = gram_rd_data_avail[b]
                                & ~(apb_rd_q && apb_rd_bank_q == gram_pkg::gram_id_t'(b));
    end
  end

endmodule

// File: source/mmacc_feed.sv
// Product feed with read request issue and a delay line aligned to the read return
`timescale 1ns/10ps
`include "mmacc_params.svh"

module mmacc_feed (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic                            enable,
  input  logic                            overwrite,
  input  logic                            prod_valid,
  input  gram_pkg::gram_id_t              prod_bank,
  input  gram_pkg::gram_add_t             prod_add,
  input  gram_pkg::coef_t [`LANES-1:0]    prod_data,
  output logic                            a0_do_read,
  output gram_pkg::gram_add_t             a0_rd_add,
  output gram_pkg::gram_id_t              a0_rd_grid,
  output logic                            s0_mask_null,
  output logic                            s1_avail,
  output gram_pkg::gram_add_t             s1_add,
  output gram_pkg::gram_id_t              s1_grid,
  output gram_pkg::coef_t [`LANES-1:0]    s1_ntt_acc_data,
  output gram_pkg::gram_1h_t              busy_1h
);

  // Read return lands at stage DLY
  // Write-back done by stage TRK
  localparam int DLY = 5;
  localparam int TRK = 8;

  gram_pkg::gram_1h_t [TRK:1]              trk_1h;
  gram_pkg::gram_1h_t                      a0_1h;
  gram_pkg::gram_id_t [DLY:1]              d_bank;
  gram_pkg::gram_add_t [DLY:1]             d_add;
  // Overwrite flag is used one stage before the payload
  logic [DLY-1:1]                          d_ovw;
  gram_pkg::coef_t [DLY:1][`LANES-1:0]     d_data;

  // Products while disabled are dropped here
  assign a0_do_read = prod_valid & enable;
  assign a0_rd_add  = prod_add;
  assign a0_rd_grid = prod_bank;
  assign a0_1h      = {`GRAM_NB{a0_do_read}} & (gram_pkg::gram_1h_t'(1) << prod_bank);

  // Bank occupancy that also carries the valid bit
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      trk_1h <= '0;
    end else begin
      trk_1h <= {trk_1h[TRK-1:1], a0_1h};
    end
  end

  // Payload delay line
  always_ff @(posedge clk) begin
    d_bank <= {d_bank[DLY-1:1], prod_bank};
    d_add  <= {d_add[DLY-1:1], prod_add};
    d_ovw  <= {d_ovw[DLY-2:1], overwrite};
    d_data <= {d_data[DLY-1:1], prod_data};
  end

  assign s0_mask_null    = d_ovw[DLY-1];
  assign s1_avail        = |trk_1h[DLY];
  assign s1_add          = d_add[DLY];
  assign s1_grid         = d_bank[DLY];
  assign s1_ntt_acc_data = d_data[DLY];

  always_comb begin
    busy_1h = '0;
    for (int i = 1; i <= TRK; i++) begin
      busy_1h = busy_1h | trk_1h[i];
    end
  end

endmodule

// File: source/mmacc_acc_write.sv
// Accumulate and write: GRAM read request, lane-wise sum, write-back
`timescale 1ns/10ps
`include "mmacc_params.svh"

module mmacc_acc_write (
  input  logic                                          clk,
  input  logic                                          s_rst_n,
  input  gram_pkg::gram_1h_t                            garb_acc_wr_avail_1h,
  input  logic                                          a0_do_read,
  input  gram_pkg::gram_add_t                           a0_rd_add,
  input  gram_pkg::gram_id_t                            a0_rd_grid,
  input  logic                                          s0_mask_null,
  input  gram_pkg::coef_t [`LANES-1:0]                  s1_ntt_acc_data,
  input  logic                                          s1_avail,
  input  gram_pkg::gram_add_t                           s1_add,
  input  gram_pkg::gram_id_t                            s1_grid,
  output logic [`GRAM_NB-1:0]                           acc_gram_rd_en,
  output gram_pkg::gram_add_t [`GRAM_NB-1:0]            acc_gram_rd_add,
  input  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    gram_acc_rd_data,
  input  logic [`GRAM_NB-1:0]                           gram_acc_rd_data_avail,
  output logic [`GRAM_NB-1:0][`LANES-1:0]               acc_gram_wr_en,
  output gram_pkg::gram_add_t [`GRAM_NB-1:0]            acc_gram_wr_add,
  output gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]    acc_gram_wr_data,
  output logic                                          error
);

  gram_pkg::gram_1h_t                              wr_avail_1h;
  logic                                            a1_rd_en;
  gram_pkg::gram_add_t                             a1_rd_add;
  gram_pkg::gram_1h_t                              a1_rd_grid_1h;
  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0]      s0_rd_data;
  logic [`GRAM_NB-1:0]                             s0_rd_avail;
  gram_pkg::coef_t [`LANES-1:0]                    s0_rd_merged;
  gram_pkg::coef_t [`LANES-1:0]                    s1_rd_data;
  gram_pkg::coef_t [`LANES-1:0]                    s1_sum;
  logic                                            s1_access_error;
  logic                                            s2_wr_en;
  gram_pkg::gram_add_t                             s2_wr_add;
  gram_pkg::gram_1h_t                              s2_wr_grid_1h;
  gram_pkg::coef_t [`LANES-1:0]                    s2_wr_data;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_avail_1h <= '0;
    end else begin
      wr_avail_1h <= garb_acc_wr_avail_1h;
    end
  end

  // ==========================================================================
  // A1/A2: read request, two registered stages
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      a1_rd_en       <= 1'b0;
      acc_gram_rd_en <= '0;
    end else begin
      a1_rd_en       <= a0_do_read;
      // Target bank only
      acc_gram_rd_en <= {`GRAM_NB{a1_rd_en}} & a1_rd_grid_1h;
    end
  end

  always_ff @(posedge clk) begin
    a1_rd_add       <= a0_rd_add;
    a1_rd_grid_1h   <= gram_pkg::gram_1h_t'(1) << a0_rd_grid;
    acc_gram_rd_add <= {`GRAM_NB{a1_rd_add}};
  end

  // ==========================================================================
  // S0: read data collection
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_rd_avail <= '0;
    end else begin
      s0_rd_avail <= gram_acc_rd_data_avail;
    end
  end

  always_ff @(posedge clk) begin
    s0_rd_data <= gram_acc_rd_data;
  end

  // Only one bank answers, OR after masking
  always_comb begin
    s0_rd_merged = '0;
    for (int b = 0; b < `GRAM_NB; b++) begin
      s0_rd_merged = s0_rd_merged | (s0_rd_data[b] & {(`LANES*`MOD_Q_W){s0_rd_avail[b]}});
    end
    // Overwrite mode adds to zero
    if (s0_mask_null) begin
      s0_rd_merged = '0;
    end
  end

  always_ff @(posedge clk) begin
    s1_rd_data <= s0_rd_merged;
  end

  // ==========================================================================
  // S1: lane-wise sum, wraps mod 2^MOD_Q_W
  // ==========================================================================
  always_comb begin
    for (int l = 0; l < `LANES; l++) begin
      s1_sum[l] = s1_ntt_acc_data[l] + s1_rd_data[l];
    end
  end

  // Bank taken by APB when we need to write
  assign s1_access_error = s1_avail & ~wr_avail_1h[s1_grid];

  // ==========================================================================
  // S2/S3: write-back, two registered stages
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s2_wr_en       <= 1'b0;
      acc_gram_wr_en <= '0;
      error          <= 1'b0;
    end else begin
      s2_wr_en <= s1_avail;
      for (int b = 0; b < `GRAM_NB; b++) begin
        acc_gram_wr_en[b] <= {`LANES{s2_wr_en & s2_wr_grid_1h[b]}};
      end
      error <= s1_access_error;
    end
  end

  always_ff @(posedge clk) begin
    s2_wr_add     <= s1_add;
    s2_wr_grid_1h <= gram_pkg::gram_1h_t'(1) << s1_grid;
    s2_wr_data    <= s1_sum;
    for (int b = 0; b < `GRAM_NB; b++) begin
      acc_gram_wr_add[b]  <= s2_wr_add;
      acc_gram_wr_data[b] <= s2_wr_data;
    end
  end

endmodule

// File: source/mmacc_apb_regs.sv
// APB slave: control and status registers, write-back counter, GRAM window
`timescale 1ns/10ps
`include "mmacc_params.svh"

module mmacc_apb_regs (
  input  logic                      clk,
  input  logic                      s_rst_n,
  input  logic [`APB_ADD_W-1:0]     paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`APB_DATA_W-1:0]    pwdata,
  output logic [`APB_DATA_W-1:0]    prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      enable,
  output logic                      overwrite,
  input  logic                      acc_error,
  input  logic                      wr_done,
  output logic                      apb_gram_req,
  output logic                      apb_gram_wr,
  output gram_pkg::gram_id_t        apb_gram_bank,
  output gram_pkg::gram_add_t       apb_gram_add,
  output logic [`LANE_W-1:0]        apb_gram_lane,
  output gram_pkg::coef_t           apb_gram_wdata,
  input  logic                      apb_gram_gnt,
  input  gram_pkg::coef_t           apb_gram_rdata
);

  mmacc_pkg::apb_state_e     state;
  mmacc_pkg::apb_reg_e       sel;
  logic                      sel_ok;
  logic                      setup;
  logic [1:0]                ctrl;
  logic                      err_sticky;
  logic [`APB_DATA_W-1:0]    count;

  // ==========================================================================
  // Decode
  // ==========================================================================
  always_comb begin
    sel    = mmacc_pkg::REG_CTRL;
    sel_ok = 1'b1;
    if (paddr[`APB_GRAM_BIT]) begin
      sel = mmacc_pkg::REG_GRAM;
    end else begin
      case (paddr)
        `APB_CTRL_OFS:   sel = mmacc_pkg::REG_CTRL;
        `APB_STATUS_OFS: sel = mmacc_pkg::REG_STATUS;
        `APB_COUNT_OFS:  sel = mmacc_pkg::REG_COUNT;
        default:         sel_ok = 1'b0;
      endcase
    end
  end

  assign setup = (state == mmacc_pkg::IDLE) && psel && !penable;

  // Window fields held stable by the master
  assign apb_gram_req   = (state == mmacc_pkg::WAIT_GRANT);
  assign apb_gram_wr    = pwrite;
  assign apb_gram_bank  = paddr[`APB_GRAM_BANK_BIT];
  assign apb_gram_add   = paddr[`APB_GRAM_ADD_LSB +: `GRAM_ADD_W];
  assign apb_gram_lane  = paddr[`LANE_W-1:0];
  assign apb_gram_wdata = pwdata;

  // ==========================================================================
  // FSM
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state   <= mmacc_pkg::IDLE;
      pready  <= 1'b0;
      pslverr <= 1'b0;
      ctrl    <= '0;
    end else begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
      case (state)
        mmacc_pkg::IDLE: begin
          if (setup && sel_ok && sel == mmacc_pkg::REG_GRAM) begin
            state <= mmacc_pkg::WAIT_GRANT;
          end else if (setup) begin
            // Registers answer with no wait state
            state   <= mmacc_pkg::DONE;
            pready  <= 1'b1;
            pslverr <= !sel_ok || (pwrite && sel != mmacc_pkg::REG_CTRL);
            if (pwrite && sel_ok && sel == mmacc_pkg::REG_CTRL) begin
              ctrl <= pwdata[1:0];
            end
          end
        end
        mmacc_pkg::WAIT_GRANT: begin
          if (apb_gram_gnt && pwrite) begin
            state  <= mmacc_pkg::DONE;
            pready <= 1'b1;
          end else if (apb_gram_gnt) begin
            state <= mmacc_pkg::READ_DATA;
          end
        end
        mmacc_pkg::READ_DATA: begin
          state  <= mmacc_pkg::DONE;
          pready <= 1'b1;
        end
        default: state <= mmacc_pkg::IDLE;
      endcase
    end
  end

  // Read data
  always_ff @(posedge clk) begin
    if (setup) begin
      case (sel)
        mmacc_pkg::REG_STATUS: prdata <= {{(`APB_DATA_W-1){1'b0}}, err_sticky};
        mmacc_pkg::REG_COUNT:  prdata <= count;
        default:               prdata <= {{(`APB_DATA_W-2){1'b0}}, ctrl};
      endcase
    end else if (state == mmacc_pkg::READ_DATA) begin
      prdata <= apb_gram_rdata;
    end
  end

  // Sticky error and write-back count
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      err_sticky <= 1'b0;
      count      <= '0;
    end else begin
      err_sticky <= err_sticky | acc_error;
      if (wr_done) begin
        count <= count + 1'b1;
      end
    end
  end

  assign enable    = ctrl[0];
  assign overwrite = ctrl[1];

endmodule

// File: source/mmacc_top.sv
// Accumulation stage top: feed, accumulate/write, arbiter, GRAM banks, APB slave
`timescale 1ns/10ps
`include "mmacc_params.svh"

module mmacc_top (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic [`APB_ADD_W-1:0]           paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [`APB_DATA_W-1:0]          pwdata,
  output logic [`APB_DATA_W-1:0]          prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  logic                            prod_valid,
  input  gram_pkg::gram_id_t              prod_bank,
  input  gram_pkg::gram_add_t             prod_add,
  input  gram_pkg::coef_t [`LANES-1:0]    prod_data
);

  logic enable, overwrite, acc_error, wr_done;
  logic apb_gram_req, apb_gram_wr, apb_gram_gnt;
  gram_pkg::gram_id_t apb_gram_bank;
  gram_pkg::gram_add_t apb_gram_add;
  logic [`LANE_W-1:0] apb_gram_lane;
  gram_pkg::coef_t apb_gram_wdata, apb_gram_rdata;
  logic a0_do_read, s0_mask_null, s1_avail;
  gram_pkg::gram_add_t a0_rd_add, s1_add;
  gram_pkg::gram_id_t a0_rd_grid, s1_grid;
  gram_pkg::coef_t [`LANES-1:0] s1_ntt_acc_data;
  gram_pkg::gram_1h_t busy_1h, prod_bank_1h, garb_acc_wr_avail_1h;
  // Pipeline and bank side ports
  logic [`GRAM_NB-1:0] acc_gram_rd_en, gram_acc_rd_data_avail, gram_rd_en, gram_rd_data_avail;
  gram_pkg::gram_add_t [`GRAM_NB-1:0] acc_gram_rd_add, acc_gram_wr_add;
  gram_pkg::gram_add_t [`GRAM_NB-1:0] gram_rd_add, gram_wr_add;
  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0] gram_acc_rd_data, acc_gram_wr_data;
  gram_pkg::coef_t [`GRAM_NB-1:0][`LANES-1:0] gram_rd_data, gram_wr_data;
  logic [`GRAM_NB-1:0][`LANES-1:0] acc_gram_wr_en, gram_wr_en;

  // Bank receiving a new product this cycle
  assign prod_bank_1h = {`GRAM_NB{a0_do_read}} & (gram_pkg::gram_1h_t'(1) << a0_rd_grid);
  assign wr_done      = |acc_gram_wr_en;

  mmacc_apb_regs mmacc_apb_regs_i (.*);
  mmacc_feed mmacc_feed_i (.*);
  mmacc_acc_write mmacc_acc_write_i (.*, .error(acc_error));
  gram_arbiter gram_arbiter_i (.*);

  for (genvar b = 0; b < `GRAM_NB; b++) begin : gen_bank
    gram_bank gram_bank_i (
      .clk           (clk),
      .s_rst_n       (s_rst_n),
      .rd_en         (gram_rd_en[b]),
      .rd_add        (gram_rd_add[b]),
      .rd_data       (gram_rd_data[b]),
      .rd_data_avail (gram_rd_data_avail[b]),
      .wr_en         (gram_wr_en[b]),
      .wr_add        (gram_wr_add[b]),
      .wr_data       (gram_wr_data[b])
    );
  end

endmodule

// File: tests/tb_mmacc_top.sv
// Accumulation stage testbench with APB and product tasks, GRAM model and directed tests
`timescale 1ns/10ps
`include "mmacc_params.svh"

module tb_mmacc_top;

  // Roughly ten times the length of all tests
  localparam int MAX_CYCLES = 20000;
  // Groups loaded per bank
  localparam int NADD = 8;

  logic                           clk;
  logic                           s_rst_n;
  logic [`APB_ADD_W-1:0]          paddr;
  logic                           psel;
  logic                           penable;
  logic                           pwrite;
  logic [`APB_DATA_W-1:0]         pwdata;
  logic [`APB_DATA_W-1:0]         prdata;
  logic                           pready;
  logic                           pslverr;
  logic                           prod_valid;
  gram_pkg::gram_id_t             prod_bank;
  gram_pkg::gram_add_t            prod_add;
  gram_pkg::coef_t [`LANES-1:0]   prod_data;

  // Expected GRAM contents
  logic [`MOD_Q_W-1:0] model [0:`GRAM_NB-1][0:NADD-1][0:`LANES-1];
  logic [1:0]          ctrl_shadow;
  int                  accepted;
  int                  cycles;

  mmacc_top mmacc_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Returns aligned to 2 ns after a rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic apb_write(input logic [`APB_ADD_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #2;
    penable = 1'b1;
    // Sampled mid-cycle and completed at the next edge
    @(negedge clk);
    while (!pready) @(negedge clk);
    err = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADD_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_ctrl(input logic [1:0] value);
    logic err;
    apb_write(`APB_CTRL_OFS, {30'd0, value}, err);
    check_value("pslverr", err, 1'b0);
    ctrl_shadow = value;
  endtask

  // Window offset from bank, group address and lane
  function automatic logic [`APB_ADD_W-1:0] window_addr(input int bank, input int add,
                                                       input int lane);
    window_addr = (`APB_ADD_W'(1) << `APB_GRAM_BIT)
                | (`APB_ADD_W'(bank) << `APB_GRAM_BANK_BIT)
                | (`APB_ADD_W'(add) << `APB_GRAM_ADD_LSB)
                | `APB_ADD_W'(lane);
  endfunction

  // One product for one cycle with the model updated by the accumulate rule
  task automatic send_product(input int bank, input int add);
    gram_pkg::coef_t [`LANES-1:0] data;
    for (int l = 0; l < `LANES; l++) begin
      data[l] = $urandom();
    end
    prod_valid = 1'b1;
    prod_bank  = gram_pkg::gram_id_t'(bank);
    prod_add   = gram_pkg::gram_add_t'(add);
    prod_data  = data;
    if (ctrl_shadow[0]) begin
      accepted++;
      for (int l = 0; l < `LANES; l++) begin
        // Overwrite keeps the product alone and a sum wraps at 2^32
        model[bank][add][l] = ctrl_shadow[1] ? data[l] : model[bank][add][l] + data[l];
      end
    end
    @(posedge clk);
    #2;
    prod_valid = 1'b0;
  endtask

  task automatic verify_group(input int bank, input int add);
    logic [31:0] rd;
    logic        err;
    for (int l = 0; l < `LANES; l++) begin
      apb_read(window_addr(bank, add, l), rd, err);
      check_value("pslverr", err, 1'b0);
      check_value($sformatf("gram[%0d][%0d][%0d]", bank, add, l), rd, model[bank][add][l]);
    end
  endtask

  task automatic verify_all;
    for (int b = 0; b < `GRAM_NB; b++) begin
      for (int a = 0; a < NADD; a++) begin
        verify_group(b, a);
      end
    end
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic reset_values_check;
    logic [31:0] rd;
    logic        err;
    apb_read(`APB_CTRL_OFS, rd, err);
    check_value("ctrl", rd, 32'd0);
    apb_read(`APB_STATUS_OFS, rd, err);
    check_value("status", rd, 32'd0);
    apb_read(`APB_COUNT_OFS, rd, err);
    check_value("count", rd, 32'd0);
    set_ctrl(2'b11);
    apb_read(`APB_CTRL_OFS, rd, err);
    check_value("ctrl", rd, 32'd3);
    set_ctrl(2'b00);
    // COUNT is read-only
    apb_write(`APB_COUNT_OFS, 32'h1234, err);
    check_value("pslverr", err, 1'b1);
    apb_read(`APB_COUNT_OFS, rd, err);
    check_value("count", rd, 32'd0);
  endtask

  task automatic window_roundtrip;
    logic err;
    for (int b = 0; b < `GRAM_NB; b++) begin
      for (int a = 0; a < NADD; a++) begin
        for (int l = 0; l < `LANES; l++) begin
          model[b][a][l] = $urandom();
          apb_write(window_addr(b, a, l), model[b][a][l], err);
          check_value("pslverr", err, 1'b0);
        end
      end
    end
    verify_all();
  endtask

  // Products spaced apart to avoid the same-address hazard
  task automatic accumulate_sums;
    set_ctrl(2'b01);
    for (int i = 0; i < 12; i++) begin
      send_product($urandom() % `GRAM_NB, $urandom() % NADD);
      wait_cycles(8);
    end
    verify_all();
  endtask

  task automatic overwrite_products;
    set_ctrl(2'b11);
    for (int i = 0; i < 6; i++) begin
      send_product($urandom() % `GRAM_NB, $urandom() % NADD);
      wait_cycles(8);
    end
    verify_all();
  endtask

  // Window reads must stall until the banks drain
  task automatic burst_with_apb;
    set_ctrl(2'b01);
    fork
      begin
        for (int i = 0; i < 2 * NADD; i++) begin
          send_product(i % 2, i / 2);
        end
      end
      begin
        wait_cycles(3);
        verify_group(0, 0);
        verify_group(1, NADD - 1);
      end
    join
    wait_cycles(8);
    verify_all();
  endtask

  task automatic disabled_drop;
    logic [31:0] rd;
    logic        err;
    set_ctrl(2'b00);
    for (int i = 0; i < 6; i++) begin
      send_product($urandom() % `GRAM_NB, $urandom() % NADD);
    end
    wait_cycles(10);
    verify_all();
    apb_read(`APB_COUNT_OFS, rd, err);
    check_value("count", rd, accepted);
    apb_read(`APB_STATUS_OFS, rd, err);
    check_value("status", rd, 32'd0);
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'hec83583f));
    s_rst_n     = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    prod_valid  = 1'b0;
    prod_bank   = '0;
    prod_add    = '0;
    prod_data   = '0;
    ctrl_shadow = 2'b00;
    accepted    = 0;
    cycles      = 0;
    repeat (5) @(posedge clk);
    #2;
    s_rst_n = 1'b1;
    wait_cycles(1);

    reset_values_check();
    window_roundtrip();
    accumulate_sums();
    overwrite_products();
    burst_with_apb();
    disabled_drop();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
source/gram_pkg.sv
source/mmacc_pkg.sv
source/gram_bank.sv
source/gram_arbiter.sv
source/mmacc_feed.sv
source/mmacc_acc_write.sv
source/mmacc_apb_regs.sv
source/mmacc_top.sv
tests/tb_mmacc_top.sv
